/* verilog/issue_pkg.sv */
package issue_pkg;

    // Datapath and physical register file
    localparam int XLEN       = 32;
    localparam int PREG_COUNT = 32;
    localparam int TAG_W      = $clog2(PREG_COUNT);
    // Load-immediate field, zero-extended to XLEN
    localparam int IMM_W      = 16;

    // Reservation table sizing
    localparam int RS_DEPTH = 8;
    localparam int RS_IDX_W = $clog2(RS_DEPTH);
    localparam int RS_CNT_W = $clog2(RS_DEPTH + 1);
    // Full rises one early, the entry in operand fetch still needs a slot
    localparam int RS_FULL_LEVEL = RS_DEPTH - 1;

    // Register stages in the multiplier
    localparam int MUL_LATENCY = 3;

    // OP_MUL goes to the multiplier, everything else to the ALU
    typedef enum logic [2:0] {
        OP_LI,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_MUL
    } opcode_e;

    // Renamed instruction from the front end
    typedef struct packed {
        opcode_e            opcode;
        logic [TAG_W-1:0]   dest;
        logic [TAG_W-1:0]   src1;
        logic [TAG_W-1:0]   src2;
        logic [IMM_W-1:0]   imm;
    } dispatch_entry_t;

    // One reservation table slot
    typedef struct packed {
        opcode_e            opcode;
        logic [TAG_W-1:0]   dest;
        logic [TAG_W-1:0]   src1;
        logic [TAG_W-1:0]   src2;
        logic [XLEN-1:0]    val1;
        logic [XLEN-1:0]    val2;
        logic               met1;
        logic               met2;
    } rs_entry_t;

    // Issue toward a functional unit
    typedef struct packed {
        logic               valid;
        opcode_e            opcode;
        logic [TAG_W-1:0]   dest;
        logic [XLEN-1:0]    op1;
        logic [XLEN-1:0]    op2;
    } fu_input_t;

    // Per-unit broadcast, also the register file write port
    typedef struct packed {
        logic               valid;
        logic [TAG_W-1:0]   tag;
        logic [XLEN-1:0]    value;
    } result_bus_t;

endpackage : issue_pkg

/* verilog/phys_regfile.sv */
`timescale 1ns/100ps

module phys_regfile
    import issue_pkg::*;
(
    input  logic                clk,
    input  logic [TAG_W-1:0]    rd_tag1,
    input  logic [TAG_W-1:0]    rd_tag2,
    input  result_bus_t         alu_result,
    input  result_bus_t         mul_result,
    output logic [XLEN-1:0]     rd_data1,
    output logic [XLEN-1:0]     rd_data2
);

    logic [XLEN-1:0] regs [PREG_COUNT];

    // Same-cycle write wins over the stored word
    function automatic logic [XLEN-1:0] read_port(
        input logic [TAG_W-1:0] tag,
        input logic [XLEN-1:0]  stored,
        input result_bus_t      a,
        input result_bus_t      m
    );
        if (a.valid && a.tag == tag) begin
            return a.value;
        end
        if (m.valid && m.tag == tag) begin
            return m.value;
        end
        return stored;
    endfunction

    // Two write ports, renaming keeps their tags apart
    always_ff @(posedge clk) begin
        if (alu_result.valid) begin
            regs[alu_result.tag] <= alu_result.value;
        end
        if (mul_result.valid) begin
            regs[mul_result.tag] <= mul_result.value;
        end
    end

    assign rd_data1 = read_port(rd_tag1, regs[rd_tag1], alu_result, mul_result);
    assign rd_data2 = read_port(rd_tag2, regs[rd_tag2], alu_result, mul_result);

endmodule : phys_regfile

/* verilog/operand_fetch.sv */
`timescale 1ns/100ps

module operand_fetch
    import issue_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatch_valid,
    input  dispatch_entry_t     dispatch,
    input  logic [XLEN-1:0]     rd_data1,
    input  logic [XLEN-1:0]     rd_data2,
    input  result_bus_t         alu_result,
    input  result_bus_t         mul_result,
    output logic [TAG_W-1:0]    rd_tag1,
    output logic [TAG_W-1:0]    rd_tag2,
    output logic                fetched_valid,
    output rs_entry_t           fetched
);

    // One bit per physical tag, high once its value is in the register file
    logic [PREG_COUNT-1:0] ready;
    rs_entry_t             fetch_next;

    // True when either result bus carries this tag in the current cycle
    function automatic logic on_bus(
        input logic [TAG_W-1:0] tag,
        input result_bus_t      a,
        input result_bus_t      m
    );
        return (a.valid && a.tag == tag) || (m.valid && m.tag == tag);
    endfunction

    // Register file is read in the dispatch cycle
    assign rd_tag1 = dispatch.src1;
    assign rd_tag2 = dispatch.src2;

    always_comb begin
        fetch_next.opcode = dispatch.opcode;
        fetch_next.dest   = dispatch.dest;
        fetch_next.src1   = dispatch.src1;
        fetch_next.src2   = dispatch.src2;
        if (dispatch.opcode == OP_LI) begin
            // Immediate rides in source 1, nothing to wait for
            fetch_next.val1 = XLEN'(dispatch.imm);
            fetch_next.val2 = '0;
            fetch_next.met1 = 1'b1;
            fetch_next.met2 = 1'b1;
        end else begin
            // Write-through read already forwards a value broadcast this cycle
            fetch_next.val1 = rd_data1;
            fetch_next.val2 = rd_data2;
            fetch_next.met1 = ready[dispatch.src1]
                              || on_bus(dispatch.src1, alu_result, mul_result);
            fetch_next.met2 = ready[dispatch.src2]
                              || on_bus(dispatch.src2, alu_result, mul_result);
        end
    end

    // Scoreboard and stage valid
    always_ff @(posedge clk) begin
        if (rst) begin
            ready         <= '1;
            fetched_valid <= 1'b0;
        end else begin
            if (alu_result.valid) begin
                ready[alu_result.tag] <= 1'b1;
            end
            if (mul_result.valid) begin
                ready[mul_result.tag] <= 1'b1;
            end
            // New destination goes pending, wins over a stale set
            if (dispatch_valid) begin
                ready[dispatch.dest] <= 1'b0;
            end
            fetched_valid <= dispatch_valid;
        end
    end

    // Stage payload
    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            fetched <= fetch_next;
        end
    end

endmodule : operand_fetch

/* verilog/reservation.sv */
`timescale 1ns/100ps

module reservation
    import issue_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            fetched_valid,
    input  rs_entry_t       fetched,
    input  result_bus_t     alu_result,
    input  result_bus_t     mul_result,
    output fu_input_t       alu_issue,
    output fu_input_t       mul_issue,
    output logic            table_full
);

    rs_entry_t              table_q [RS_DEPTH];
    logic [RS_DEPTH-1:0]    valid_q;

    logic                   alloc_found;
    logic [RS_IDX_W-1:0]    alloc_idx;
    logic                   alu_found;
    logic [RS_IDX_W-1:0]    alu_idx;
    logic                   mul_found;
    logic [RS_IDX_W-1:0]    mul_idx;
    logic [RS_CNT_W-1:0]    occupancy;

    // Capture any unmet source broadcast on either bus
    function automatic rs_entry_t wake(
        input rs_entry_t   e,
        input result_bus_t a,
        input result_bus_t m
    );
        result_bus_t bus [2];
        rs_entry_t   r;
        bus[0] = a;
        bus[1] = m;
        r      = e;
        for (int b = 0; b < 2; b++) begin
            if (!e.met1 && bus[b].valid && bus[b].tag == e.src1) begin
                r.met1 = 1'b1;
                r.val1 = bus[b].value;
            end
            if (!e.met2 && bus[b].valid && bus[b].tag == e.src2) begin
                r.met2 = 1'b1;
                r.val2 = bus[b].value;
            end
        end
        return r;
    endfunction

    function automatic fu_input_t to_fu(input logic found, input rs_entry_t e);
        fu_input_t f;
        f.valid  = found;
        f.opcode = e.opcode;
        f.dest   = e.dest;
        f.op1    = e.val1;
        f.op2    = e.val2;
        return f;
    endfunction

    // Free slot, ready selects and occupancy
    always_comb begin
        alloc_found = 1'b0;
        alloc_idx   = '0;
        alu_found   = 1'b0;
        alu_idx     = '0;
        mul_found   = 1'b0;
        mul_idx     = '0;
        occupancy   = '0;
        // Walk downward so the lowest index is the last one kept
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                alloc_found = 1'b1;
                alloc_idx   = RS_IDX_W'(i);
            end else if (table_q[i].met1 && table_q[i].met2) begin
                if (table_q[i].opcode == OP_MUL) begin
                    mul_found = 1'b1;
                    mul_idx   = RS_IDX_W'(i);
                end else begin
                    alu_found = 1'b1;
                    alu_idx   = RS_IDX_W'(i);
                end
            end
            occupancy = occupancy + RS_CNT_W'(valid_q[i]);
        end
    end

    // Front end pauses at this level
    assign table_full = (occupancy >= RS_CNT_W'(RS_FULL_LEVEL));

    // Slot valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            if (fetched_valid && alloc_found) begin
                valid_q[alloc_idx] <= 1'b1;
            end
            // Issued slots free at the same edge the issue register loads
            if (alu_found) begin
                valid_q[alu_idx] <= 1'b0;
            end
            if (mul_found) begin
                valid_q[mul_idx] <= 1'b0;
            end
        end
    end

    // Slot payload, wakeup on stored and incoming entries
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (valid_q[i]) begin
                table_q[i] <= wake(table_q[i], alu_result, mul_result);
            end
        end
        // A broadcast during allocation would otherwise be missed
        if (fetched_valid && alloc_found) begin
            table_q[alloc_idx] <= wake(fetched, alu_result, mul_result);
        end
    end

    // Issue registers, one per unit
    always_ff @(posedge clk) begin
        alu_issue <= to_fu(alu_found, table_q[alu_idx]);
        mul_issue <= to_fu(mul_found, table_q[mul_idx]);
        if (rst) begin
            alu_issue.valid <= 1'b0;
            mul_issue.valid <= 1'b0;
        end
    end

endmodule : reservation

/* verilog/int_alu.sv */
`timescale 1ns/100ps

module int_alu
    import issue_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  fu_input_t       alu_issue,
    output result_bus_t     alu_result
);

    logic [XLEN-1:0] alu_value;

    always_comb begin
        unique case (alu_issue.opcode)
            // Immediate already sits in operand 1
            OP_LI:   alu_value = alu_issue.op1;
            OP_ADD:  alu_value = alu_issue.op1 + alu_issue.op2;
            OP_SUB:  alu_value = alu_issue.op1 - alu_issue.op2;
            OP_AND:  alu_value = alu_issue.op1 & alu_issue.op2;
            OP_OR:   alu_value = alu_issue.op1 | alu_issue.op2;
            OP_XOR:  alu_value = alu_issue.op1 ^ alu_issue.op2;
            // Shift amount from the low 5 bits, as in RV32I
            OP_SLL:  alu_value = alu_issue.op1 << alu_issue.op2[4:0];
            // Multiplies never reach this unit
            default: alu_value = '0;
        endcase
    end

    // Result register, one cycle after issue
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_result.valid <= 1'b0;
        end else begin
            alu_result.valid <= alu_issue.valid;
        end
        alu_result.tag   <= alu_issue.dest;
        alu_result.value <= alu_value;
    end

endmodule : int_alu

/* verilog/mul_unit.sv */
`timescale 1ns/100ps

module mul_unit
    import issue_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  fu_input_t       mul_issue,
    output result_bus_t     mul_result
);

    // Partial products of the 16-bit halves, high by high drops out of the low word
    logic [XLEN-1:0]        pp_ll;
    logic [XLEN-1:0]        pp_lh;
    logic [XLEN-1:0]        pp_hl;
    logic [XLEN-1:0]        sum_q;
    logic [XLEN-1:0]        product_q;

    // Valid and tag move with the data, one slot per stage
    logic [MUL_LATENCY-1:0] valid_pipe;
    logic [TAG_W-1:0]       tag_pipe [MUL_LATENCY];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[MUL_LATENCY-2:0], mul_issue.valid};
        end
        tag_pipe[0] <= mul_issue.dest;
        for (int s = 1; s < MUL_LATENCY; s++) begin
            tag_pipe[s] <= tag_pipe[s-1];
        end
    end

    always_ff @(posedge clk) begin
        // Stage 1
        pp_ll <= mul_issue.op1[XLEN/2-1:0] * mul_issue.op2[XLEN/2-1:0];
        pp_lh <= mul_issue.op1[XLEN/2-1:0] * mul_issue.op2[XLEN-1:XLEN/2];
        pp_hl <= mul_issue.op1[XLEN-1:XLEN/2] * mul_issue.op2[XLEN/2-1:0];
        // Stage 2, cross terms shifted up and truncated
        sum_q <= pp_ll + ((pp_lh + pp_hl) << (XLEN/2));
        // Stage 3
        product_q <= sum_q;
    end

    assign mul_result.valid = valid_pipe[MUL_LATENCY-1];
    assign mul_result.tag   = tag_pipe[MUL_LATENCY-1];
    assign mul_result.value = product_q;

endmodule : mul_unit

/* verilog/issue_core.sv */
`timescale 1ns/100ps

module issue_core
    import issue_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            dispatch_valid,
    input  dispatch_entry_t dispatch,
    output logic            table_full,
    output result_bus_t     alu_result,
    output result_bus_t     mul_result
);

    // Operand fetch to register file and table
    logic [TAG_W-1:0]   rd_tag1;
    logic [TAG_W-1:0]   rd_tag2;
    logic [XLEN-1:0]    rd_data1;
    logic [XLEN-1:0]    rd_data2;
    logic               fetched_valid;
    rs_entry_t          fetched;

    // Table to units
    fu_input_t          alu_issue;
    fu_input_t          mul_issue;

    operand_fetch operand_fetch_inst (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .rd_data1       (rd_data1),
        .rd_data2       (rd_data2),
        .alu_result     (alu_result),
        .mul_result     (mul_result),
        .rd_tag1        (rd_tag1),
        .rd_tag2        (rd_tag2),
        .fetched_valid  (fetched_valid),
        .fetched        (fetched)
    );

    // Result buses double as the write ports
    phys_regfile phys_regfile_inst (
        .clk        (clk),
        .rd_tag1    (rd_tag1),
        .rd_tag2    (rd_tag2),
        .alu_result (alu_result),
        .mul_result (mul_result),
        .rd_data1   (rd_data1),
        .rd_data2   (rd_data2)
    );

    reservation reservation_inst (
        .clk           (clk),
        .rst           (rst),
        .fetched_valid (fetched_valid),
        .fetched       (fetched),
        .alu_result    (alu_result),
        .mul_result    (mul_result),
        .alu_issue     (alu_issue),
        .mul_issue     (mul_issue),
        .table_full    (table_full)
    );

    int_alu int_alu_inst (
        .clk        (clk),
        .rst        (rst),
        .alu_issue  (alu_issue),
        .alu_result (alu_result)
    );

    mul_unit mul_unit_inst (
        .clk        (clk),
        .rst        (rst),
        .mul_issue  (mul_issue),
        .mul_result (mul_result)
    );

endmodule : issue_core

/* test/issue_core_asserts.sv */
`timescale 1ns/100ps

module issue_core_asserts
    import issue_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input logic         dispatch_valid,
    input logic         table_full,
    input fu_input_t    alu_issue,
    input fu_input_t    mul_issue,
    input result_bus_t  alu_result,
    input result_bus_t  mul_result
);

    // Number of rules that have fired so far
    int fail_count = 0;

    // Front end must hold off while the table is full
    no_dispatch_when_full: assert property (@(posedge clk) disable iff (rst)
        table_full |-> !dispatch_valid)
    else begin
        $error("dispatch strobe seen while table_full is high");
        fail_count++;
    end

    // Table comes out of reset empty
    empty_after_reset: assert property (@(posedge clk)
        rst |=> !table_full)
    else begin
        $error("table_full high in the cycle after reset");
        fail_count++;
    end

    // ALU has a single register stage
    alu_one_cycle: assert property (@(posedge clk) disable iff (rst)
        alu_issue.valid |=> alu_result.valid && alu_result.tag == $past(alu_issue.dest))
    else begin
        $error("ALU result missing or mistagged one cycle after issue");
        fail_count++;
    end

    // Multiplier result and its tag arrive after the pipeline latency
    mul_fixed_latency: assert property (@(posedge clk) disable iff (rst)
        mul_issue.valid |-> ##MUL_LATENCY
            (mul_result.valid && mul_result.tag == $past(mul_issue.dest, MUL_LATENCY)))
    else begin
        $error("multiplier result missing or mistagged after its latency");
        fail_count++;
    end

endmodule : issue_core_asserts

bind issue_core issue_core_asserts issue_core_asserts_inst (.*);

/* test/issue_core_tb.sv */
`timescale 1ns/100ps

module issue_core_tb;
    import issue_pkg::*;

    // Cycles allowed for any single wait
    localparam int MAX_WAIT = 200;

    // One program row with the expected value from the reference model
    typedef struct {
        dispatch_entry_t    instr;
        int                 gap;
        logic [XLEN-1:0]    expected;
    } row_t;

    logic               clk;
    logic               rst;
    logic               dispatch_valid;
    dispatch_entry_t    dispatch;
    logic               table_full;
    result_bus_t        alu_result;
    result_bus_t        mul_result;

    row_t                   prog [$];
    logic [XLEN-1:0]        model_regs [PREG_COUNT];
    logic [XLEN-1:0]        expect_val [PREG_COUNT];
    logic [PREG_COUNT-1:0]  outstanding = '0;
    int                     written = 0;
    bit                     held_for_full = 1'b0;

    issue_core issue_core_inst (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .table_full     (table_full),
        .alu_result     (alu_result),
        .mul_result     (mul_result)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1, "Stopping at the first error");
    endtask

    // Immediates only matter for load-immediate rows
    function automatic void push_row(input opcode_e op, input int dest, input int src1,
                                     input int src2, input int gap);
        row_t r;
        r.instr.opcode = op;
        r.instr.dest   = TAG_W'(dest);
        r.instr.src1   = TAG_W'(src1);
        r.instr.src2   = TAG_W'(src2);
        r.instr.imm    = (op == OP_LI) ? IMM_W'($urandom) : '0;
        r.gap          = gap;
        r.expected     = '0;
        prog.push_back(r);
    endfunction

    // Opcode rules where multiply keeps the low word
    function automatic logic [XLEN-1:0] reference_result(input dispatch_entry_t d,
                                                         input logic [XLEN-1:0] a,
                                                         input logic [XLEN-1:0] b);
        case (d.opcode)
            OP_LI:   return {{(XLEN-IMM_W){1'b0}}, d.imm};
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            default: return a * b;
        endcase
    endfunction

    // A valid bus must carry an outstanding tag with the model's value
    task automatic check_bus(input string name, input result_bus_t bus);
        if (bus.valid) begin
            assert (outstanding[bus.tag])
            else begin
                $display("Result on %s with tag %0d that was not outstanding at %0t",
                         name, bus.tag, $time);
                stop_on_error();
            end
            assert (bus.value === expect_val[bus.tag])
            else begin
                $display("FAILED at %0t: %s.value tag %0d expected %h actual %h",
                         $time, name, bus.tag, expect_val[bus.tag], bus.value);
                stop_on_error();
            end
            outstanding[bus.tag] = 1'b0;
            written++;
        end
    endtask

    // Hold the strobe low while full, or while the destination is still in flight
    task automatic wait_until_free(input logic [TAG_W-1:0] dest);
        int cycles = 0;
        while (table_full || outstanding[dest]) begin
            if (cycles == MAX_WAIT) begin
                $display("Timed out waiting for a table slot or for tag %0d", dest);
                stop_on_error();
            end
            if (table_full) begin
                held_for_full = 1'b1;
            end
            @(posedge clk);
            #10;
            cycles++;
        end
    endtask

    // Sample at the falling edge, well away from the DUT's updates
    always @(negedge clk) begin
        if (!rst) begin
            check_bus("alu_result", alu_result);
            check_bus("mul_result", mul_result);
            // Every table entry is still in flight, so full needs enough of them
            if (table_full) begin
                assert ($countones(outstanding) >= RS_FULL_LEVEL)
                else begin
                    $display("FAILED at %0t: table_full expected 0 actual 1 (%0d in flight)",
                             $time, $countones(outstanding));
                    stop_on_error();
                end
            end
        end
        assert (issue_core_inst.issue_core_asserts_inst.fail_count == 0)
        else begin
            $display("A bound protocol assertion fired at %0t", $time);
            stop_on_error();
        end
    end

    initial begin
        int cycles;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        void'($urandom(81));

        // Seeds
        push_row(OP_LI, 1, 0, 0, 0);
        push_row(OP_LI, 2, 0, 0, 0);
        push_row(OP_LI, 3, 0, 0, 0);
        push_row(OP_LI, 4, 0, 0, 0);
        // Independent ALU operations
        push_row(OP_ADD, 5, 1, 2, 0);
        push_row(OP_SUB, 6, 3, 4, 0);
        push_row(OP_AND, 7, 1, 3, 0);
        push_row(OP_OR, 8, 2, 4, 0);
        push_row(OP_XOR, 9, 1, 4, 0);
        push_row(OP_SLL, 10, 2, 3, 0);
        // Dependent chain
        push_row(OP_ADD, 11, 5, 6, 0);
        push_row(OP_SUB, 12, 11, 7, 0);
        push_row(OP_XOR, 13, 12, 8, 0);
        push_row(OP_SLL, 14, 13, 1, 0);
        // Consumer lands in the ALU writeback cycle of its producer
        push_row(OP_LI, 15, 0, 0, 0);
        push_row(OP_ADD, 16, 15, 1, 3);
        // Same for the multiplier bus
        push_row(OP_MUL, 17, 15, 2, 0);
        push_row(OP_ADD, 18, 17, 3, 5);
        // The add overtakes the back-to-back multiplies
        push_row(OP_MUL, 19, 3, 4, 0);
        push_row(OP_MUL, 20, 1, 2, 0);
        push_row(OP_ADD, 21, 5, 9, 0);
        // Multiply chain with many waiting consumers fills the table
        push_row(OP_MUL, 22, 20, 4, 0);
        push_row(OP_MUL, 23, 22, 19, 0);
        push_row(OP_ADD, 24, 23, 1, 0);
        push_row(OP_SUB, 25, 23, 2, 0);
        push_row(OP_XOR, 26, 23, 3, 0);
        push_row(OP_OR, 27, 23, 4, 0);
        push_row(OP_AND, 28, 23, 5, 0);
        // Tag 2 reused once its old value is home
        push_row(OP_ADD, 2, 23, 26, 0);
        // These arrive while the table is full and must be held back
        push_row(OP_ADD, 29, 23, 24, 0);
        push_row(OP_SUB, 30, 28, 2, 0);

        // Reference model in program order
        foreach (prog[i]) begin
            prog[i].expected = reference_result(prog[i].instr,
                                                model_regs[prog[i].instr.src1],
                                                model_regs[prog[i].instr.src2]);
            model_regs[prog[i].instr.dest] = prog[i].expected;
        end

        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;

        foreach (prog[i]) begin
            repeat (prog[i].gap) begin
                @(posedge clk);
                #10;
            end
            wait_until_free(prog[i].instr.dest);
            dispatch                          = prog[i].instr;
            dispatch_valid                    = 1'b1;
            expect_val[prog[i].instr.dest]    = prog[i].expected;
            outstanding[prog[i].instr.dest]   = 1'b1;
            @(posedge clk);
            #10;
            dispatch_valid = 1'b0;
        end

        // Every row writes back once
        cycles = 0;
        while (written != prog.size()) begin
            if (cycles == MAX_WAIT) begin
                $display("Timed out with %0d of %0d results written back",
                         written, prog.size());
                stop_on_error();
            end
            @(posedge clk);
            cycles++;
        end
        // Idle a while so a duplicate result would still be caught
        repeat (10) @(posedge clk);

        assert (held_for_full)
        else begin
            $display("Dispatch was never held back by table_full during the fill sequence");
            stop_on_error();
        end
        $display("Testbench passed");
        $finish;
    end

endmodule : issue_core_tb

/* project.f */
verilog/issue_pkg.sv
verilog/phys_regfile.sv
verilog/operand_fetch.sv
verilog/reservation.sv
verilog/int_alu.sv
verilog/mul_unit.sv
verilog/issue_core.sv
test/issue_core_asserts.sv
test/issue_core_tb.sv
